/* src/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and pc width
`define RV_XLEN 32

// machine csr address width
`define RV_CSR_ADDR_W 12

`endif

/* src/trap_pkg.sv */
`default_nettype none

package trap_pkg;

    // trap kinds handed from the detector to the controller
    typedef enum logic [2:0] {
        TRAP_NONE            = 3'd0,
        TRAP_FENCEI          = 3'd1,
        TRAP_MRET            = 3'd2,
        TRAP_EBREAK          = 3'd3,
        TRAP_ECALL           = 3'd4,
        TRAP_MISALIGNED_INST = 3'd5,
        TRAP_MISALIGNED_MEM  = 3'd6
    } trap_kind_t;

    // pre-trap handling FSM, only used by multi-cycle traps
    typedef enum logic [1:0] {
        PTH_IDLE         = 2'd0, // mepc write happens here
        PTH_WRITE_MEPC   = 2'd1, // mcause write happens here
        PTH_WRITE_MCAUSE = 2'd2, // ebreak finishes here
        PTH_READ_MTVEC   = 2'd3
    } pth_state_t;

endpackage

`default_nettype wire

/* src/csr_pkg.sv */
`include "rv_defines.svh"

`default_nettype none

package csr_pkg;

    // machine csr addresses
    parameter logic [`RV_CSR_ADDR_W-1:0] CSR_MTVEC  = 12'h305;
    parameter logic [`RV_CSR_ADDR_W-1:0] CSR_MEPC   = 12'h341;
    parameter logic [`RV_CSR_ADDR_W-1:0] CSR_MCAUSE = 12'h342;

    // mcause exception codes, interrupt bit is always clear
    parameter logic [`RV_XLEN-1:0] CAUSE_INST_MISALIGNED = `RV_XLEN'(0);
    parameter logic [`RV_XLEN-1:0] CAUSE_BREAKPOINT      = `RV_XLEN'(3);
    parameter logic [`RV_XLEN-1:0] CAUSE_LOAD_MISALIGNED = `RV_XLEN'(4);
    parameter logic [`RV_XLEN-1:0] CAUSE_ECALL_M         = `RV_XLEN'(11);

endpackage

`default_nettype wire

/* src/trap_detector.sv */
`include "rv_defines.svh"

`default_nettype none

module trap_detector (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ecall_req,
    input  logic                       ebreak_req,
    input  logic                       fencei_req,
    input  logic                       mret_req,
    input  logic                       misaligned_inst_req,
    input  logic                       misaligned_mem_req,
    input  logic [`RV_XLEN-1:0]        id_pc,
    input  logic [`RV_XLEN-1:0]        ex_pc,
    input  logic [`RV_XLEN-1:0]        mem_pc,
    input  logic                       trap_done,
    output trap_pkg::trap_kind_t       trap_status,
    output logic [`RV_XLEN-1:0]        trap_pc
);

    trap_pkg::trap_kind_t req_kind;     // winning request this cycle
    logic [`RV_XLEN-1:0]  req_pc;

    // fixed priority, memory side faults first
    always_comb begin
        req_kind = trap_pkg::TRAP_NONE;
        req_pc   = ex_pc;
        if (misaligned_mem_req) begin
            req_kind = trap_pkg::TRAP_MISALIGNED_MEM;
            req_pc   = mem_pc;
        end else if (misaligned_inst_req) begin
            req_kind = trap_pkg::TRAP_MISALIGNED_INST;
        end else if (ecall_req) begin
            req_kind = trap_pkg::TRAP_ECALL;
            req_pc   = id_pc;       // ecall is caught in decode
        end else if (ebreak_req) begin
            req_kind = trap_pkg::TRAP_EBREAK;
        end else if (mret_req) begin
            req_kind = trap_pkg::TRAP_MRET;
        end else if (fencei_req) begin
            req_kind = trap_pkg::TRAP_FENCEI;
        end
    end

    // trap_done is high whenever the slot is free, so requests seen
    // while a trap is still running (core stalled) are simply lost
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trap_status <= trap_pkg::TRAP_NONE;
        end else if (trap_done) begin
            trap_status <= req_kind;
        end
    end

    always_ff @(posedge clk) begin
        if (trap_done) begin
            trap_pc <= req_pc;      // only meaningful next to trap_status
        end
    end

endmodule

`default_nettype wire

/* src/trap_controller.sv */
`include "rv_defines.svh"

`default_nettype none

module trap_controller (
    input  logic                         clk,
    input  logic                         reset,
    input  trap_pkg::trap_kind_t         trap_status,
    input  logic [`RV_XLEN-1:0]          trap_pc,
    input  logic [`RV_XLEN-1:0]          csr_trap_rdata,
    output logic                         csr_trap_we,
    output logic [`RV_CSR_ADDR_W-1:0]    csr_trap_addr,
    output logic [`RV_XLEN-1:0]          csr_trap_wdata,
    output logic [`RV_XLEN-1:0]          trap_target,
    output logic                         redirect_valid,
    output logic                         ic_flush,
    output logic                         debug_mode,
    output logic                         trap_done
);

    trap_pkg::pth_state_t state, next_state;
    logic                 finish;       // last working cycle of this trap
    logic                 done_q;       // releases the detector one cycle later
    logic                 debug_set;
    logic                 debug_clr;
    logic [`RV_XLEN-1:0]  cause_code;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= trap_pkg::PTH_IDLE;
            done_q     <= 1'b0;
            debug_mode <= 1'b0;
        end else begin
            state  <= next_state;
            done_q <= finish;
            if (debug_set) begin
                debug_mode <= 1'b1;
            end else if (debug_clr) begin
                debug_mode <= 1'b0;
            end
        end
    end

    // stall covers every working cycle, including the redirect cycle
    assign trap_done = done_q || (trap_status == trap_pkg::TRAP_NONE);

    always_comb begin
        case (trap_status)
            trap_pkg::TRAP_EBREAK:         cause_code = csr_pkg::CAUSE_BREAKPOINT;
            trap_pkg::TRAP_ECALL:          cause_code = csr_pkg::CAUSE_ECALL_M;
            trap_pkg::TRAP_MISALIGNED_MEM: cause_code = csr_pkg::CAUSE_LOAD_MISALIGNED;
            default:                       cause_code = csr_pkg::CAUSE_INST_MISALIGNED;
        endcase
    end

    always_comb begin
        csr_trap_we    = 1'b0;
        csr_trap_addr  = '0;
        csr_trap_wdata = '0;
        trap_target    = '0;
        redirect_valid = 1'b0;
        ic_flush       = 1'b0;
        debug_set      = 1'b0;
        debug_clr      = 1'b0;
        finish         = 1'b0;
        next_state     = state;

        if (!trap_done) begin
            case (trap_status)
                trap_pkg::TRAP_FENCEI: begin
                    ic_flush = 1'b1;
                    finish   = 1'b1;
                end
                trap_pkg::TRAP_MRET: begin
                    csr_trap_addr  = csr_pkg::CSR_MEPC;
                    // force word alignment before stepping past the trapping insn
                    trap_target    = {csr_trap_rdata[`RV_XLEN-1:2], 2'b00} + `RV_XLEN'(4);
                    redirect_valid = 1'b1;
                    debug_clr      = 1'b1;
                    finish         = 1'b1;
                end
                default: begin
                    case (state)
                        trap_pkg::PTH_IDLE: begin
                            csr_trap_we    = 1'b1;
                            csr_trap_addr  = csr_pkg::CSR_MEPC;
                            csr_trap_wdata = trap_pc;
                            next_state     = trap_pkg::PTH_WRITE_MEPC;
                        end
                        trap_pkg::PTH_WRITE_MEPC: begin
                            csr_trap_we    = 1'b1;
                            csr_trap_addr  = csr_pkg::CSR_MCAUSE;
                            csr_trap_wdata = cause_code;
                            next_state     = trap_pkg::PTH_WRITE_MCAUSE;
                        end
                        trap_pkg::PTH_WRITE_MCAUSE: begin
                            if (trap_status == trap_pkg::TRAP_EBREAK) begin
                                debug_set  = 1'b1;     // no handler jump, debugger takes over
                                finish     = 1'b1;
                                next_state = trap_pkg::PTH_IDLE;
                            end else begin
                                next_state = trap_pkg::PTH_READ_MTVEC;
                            end
                        end
                        default: begin  // PTH_READ_MTVEC
                            csr_trap_addr  = csr_pkg::CSR_MTVEC;
                            trap_target    = csr_trap_rdata;
                            redirect_valid = 1'b1;
                            finish         = 1'b1;
                            next_state     = trap_pkg::PTH_IDLE;
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/machine_csr_file.sv */
`include "rv_defines.svh"

`default_nettype none

module machine_csr_file (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         csr_trap_we,
    input  logic [`RV_CSR_ADDR_W-1:0]    csr_trap_addr,
    input  logic [`RV_XLEN-1:0]          csr_trap_wdata,
    output logic [`RV_XLEN-1:0]          csr_trap_rdata,
    input  logic                         csr_sw_we,
    input  logic [`RV_CSR_ADDR_W-1:0]    csr_sw_addr,
    input  logic [`RV_XLEN-1:0]          csr_sw_wdata,
    output logic [`RV_XLEN-1:0]          csr_sw_rdata
);

    logic [`RV_XLEN-1:0]       mepc;
    logic [`RV_XLEN-1:0]       mcause;
    logic [`RV_XLEN-1:0]       mtvec;
    logic                      wr_en;
    logic [`RV_CSR_ADDR_W-1:0] wr_addr;
    logic [`RV_XLEN-1:0]       wr_data;

    // unknown addresses read as zero
    function automatic logic [`RV_XLEN-1:0] csr_read(input logic [`RV_CSR_ADDR_W-1:0] addr);
        logic [`RV_XLEN-1:0] val;
        case (addr)
            csr_pkg::CSR_MEPC:   val = mepc;
            csr_pkg::CSR_MCAUSE: val = mcause;
            csr_pkg::CSR_MTVEC:  val = mtvec;
            default:             val = '0;
        endcase
        return val;
    endfunction

    // trap port owns the write path when active and a sw write that cycle is lost
    assign wr_en   = csr_trap_we | csr_sw_we;
    assign wr_addr = csr_trap_we ? csr_trap_addr : csr_sw_addr;
    assign wr_data = csr_trap_we ? csr_trap_wdata : csr_sw_wdata;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mepc   <= '0;
            mcause <= '0;
            mtvec  <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                csr_pkg::CSR_MEPC:   mepc   <= wr_data;
                csr_pkg::CSR_MCAUSE: mcause <= wr_data;
                csr_pkg::CSR_MTVEC:  mtvec  <= wr_data;    // direct mode only
                default: ;                                   // unknown address is dropped
            endcase
        end
    end

    // both read ports follow the registers as well as the addresses
    always_comb begin
        csr_trap_rdata = csr_read(csr_trap_addr);
        csr_sw_rdata   = csr_read(csr_sw_addr);
    end

endmodule

`default_nettype wire

/* src/trap_unit_top.sv */
`include "rv_defines.svh"

`default_nettype none

module trap_unit_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ecall_req,
    input  logic                         ebreak_req,
    input  logic                         fencei_req,
    input  logic                         mret_req,
    input  logic                         misaligned_inst_req,
    input  logic                         misaligned_mem_req,
    input  logic [`RV_XLEN-1:0]          id_pc,
    input  logic [`RV_XLEN-1:0]          ex_pc,
    input  logic [`RV_XLEN-1:0]          mem_pc,
    input  logic                         csr_sw_we,
    input  logic [`RV_CSR_ADDR_W-1:0]    csr_sw_addr,
    input  logic [`RV_XLEN-1:0]          csr_sw_wdata,
    output logic [`RV_XLEN-1:0]          csr_sw_rdata,
    output logic                         pc_stall,
    output logic                         redirect_valid,
    output logic [`RV_XLEN-1:0]          redirect_pc,
    output logic                         ic_flush,
    output logic                         debug_mode
);

    trap_pkg::trap_kind_t      trap_status;
    logic [`RV_XLEN-1:0]       trap_pc;
    logic                      trap_done;
    logic                      csr_trap_we;
    logic [`RV_CSR_ADDR_W-1:0] csr_trap_addr;
    logic [`RV_XLEN-1:0]       csr_trap_wdata;
    logic [`RV_XLEN-1:0]       csr_trap_rdata;
    logic [`RV_XLEN-1:0]       trap_target;

    assign pc_stall    = ~trap_done;    // core holds fetch while a trap runs
    assign redirect_pc = trap_target;

    trap_detector u_detector (
        .clk                 (clk),
        .reset               (reset),
        .ecall_req           (ecall_req),
        .ebreak_req          (ebreak_req),
        .fencei_req          (fencei_req),
        .mret_req            (mret_req),
        .misaligned_inst_req (misaligned_inst_req),
        .misaligned_mem_req  (misaligned_mem_req),
        .id_pc               (id_pc),
        .ex_pc               (ex_pc),
        .mem_pc              (mem_pc),
        .trap_done           (trap_done),
        .trap_status         (trap_status),
        .trap_pc             (trap_pc)
    );

    trap_controller u_controller (
        .clk            (clk),
        .reset          (reset),
        .trap_status    (trap_status),
        .trap_pc        (trap_pc),
        .csr_trap_rdata (csr_trap_rdata),
        .csr_trap_we    (csr_trap_we),
        .csr_trap_addr  (csr_trap_addr),
        .csr_trap_wdata (csr_trap_wdata),
        .trap_target    (trap_target),
        .redirect_valid (redirect_valid),
        .ic_flush       (ic_flush),
        .debug_mode     (debug_mode),
        .trap_done      (trap_done)
    );

    machine_csr_file u_csr (
        .clk            (clk),
        .reset          (reset),
        .csr_trap_we    (csr_trap_we),
        .csr_trap_addr  (csr_trap_addr),
        .csr_trap_wdata (csr_trap_wdata),
        .csr_trap_rdata (csr_trap_rdata),
        .csr_sw_we      (csr_sw_we),
        .csr_sw_addr    (csr_sw_addr),
        .csr_sw_wdata   (csr_sw_wdata),
        .csr_sw_rdata   (csr_sw_rdata)
    );

endmodule

`default_nettype wire

/* verif/trap_unit_checker.sv */
`include "rv_defines.svh"

`default_nettype none

module trap_unit_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      pc_stall,
    input  logic                      redirect_valid,
    input  logic [`RV_XLEN-1:0]       redirect_pc,
    input  logic                      ic_flush,
    input  logic                      debug_mode,
    input  logic [`RV_CSR_ADDR_W-1:0] csr_sw_addr,
    input  logic [`RV_XLEN-1:0]       csr_sw_rdata,
    input  logic                      exp_go,          // request sampled this cycle
    input  logic [2:0]                exp_len,
    input  logic                      exp_redirect,
    input  logic [`RV_XLEN-1:0]       exp_redirect_pc,
    input  logic                      exp_flush,
    input  logic                      exp_debug_set,
    input  logic                      exp_debug_clr,
    input  logic                      rd_check,
    input  logic [`RV_XLEN-1:0]       rd_expect,
    input  integer                    timeouts,
    input  logic                      report,
    output integer                    errors
);

    logic                active;
    logic [2:0]          cyc;           // cycle number inside the trap
    logic [2:0]          len;
    logic                want_redirect;
    logic [`RV_XLEN-1:0] want_pc;
    logic                want_flush;
    logic                set_dbg;
    logic                clr_dbg;
    logic                e_debug;       // modelled debug_mode

    function automatic string csr_name(input logic [`RV_CSR_ADDR_W-1:0] addr);
        case (addr)
            csr_pkg::CSR_MEPC:   return "mepc";
            csr_pkg::CSR_MCAUSE: return "mcause";
            csr_pkg::CSR_MTVEC:  return "mtvec";
            default:             return "csr_sw_rdata";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [`RV_XLEN-1:0] got,
            input logic [`RV_XLEN-1:0] want);
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got %0h expected %0h at %0t", name, got, want, $time);
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        logic stall_exp;
        logic redir_exp;
        logic flush_exp;
        if (reset) begin
            active  = 1'b0;
            cyc     = 3'd0;
            e_debug = 1'b0;
            errors  = 0;
        end else begin
            stall_exp = active && (cyc <= len);
            redir_exp = active && want_redirect && (cyc == len);
            flush_exp = active && want_flush && (cyc == len);
            compare_value("pc_stall", 32'(pc_stall), 32'(stall_exp));
            compare_value("redirect_valid", 32'(redirect_valid), 32'(redir_exp));
            compare_value("ic_flush", 32'(ic_flush), 32'(flush_exp));
            compare_value("debug_mode", 32'(debug_mode), 32'(e_debug));
            if (redir_exp) begin
                compare_value("redirect_pc", redirect_pc, want_pc);
            end
            if (rd_check) begin
                compare_value(csr_name(csr_sw_addr), csr_sw_rdata, rd_expect);
            end

            if (active) begin
                if (cyc == len) begin
                    // debug_mode moves at the edge that ends the last cycle
                    if (set_dbg) e_debug = 1'b1;
                    if (clr_dbg) e_debug = 1'b0;
                    active = 1'b0;
                end
                cyc++;
            end
            if (exp_go) begin
                active        = 1'b1;
                cyc           = 3'd1;
                len           = exp_len;
                want_redirect = exp_redirect;
                want_pc       = exp_redirect_pc;
                want_flush    = exp_flush;
                set_dbg       = exp_debug_set;
                clr_dbg       = exp_debug_clr;
            end
        end
    end

    always @(posedge report) begin
        $display("closing: %0d mismatches, %0d timeouts", errors, timeouts);
    end

endmodule

`default_nettype wire

/* verif/trap_unit_tb.sv */
`include "rv_defines.svh"

`default_nettype none

module trap_unit_tb;

    typedef struct packed {
        logic [2:0]          stall_len;
        logic                redirect;
        logic [`RV_XLEN-1:0] redirect_pc;
        logic                flush;
        logic                writes;        // mepc and mcause get written
        logic [`RV_XLEN-1:0] mepc;
        logic [`RV_XLEN-1:0] mcause;
        logic                debug_set;
        logic                debug_clr;
    } outcome_t;

    logic                      clk;
    logic                      reset;
    logic [5:0]                req_bits;    // mem, inst, mret, fencei, ebreak, ecall
    logic                      ecall_req;
    logic                      ebreak_req;
    logic                      fencei_req;
    logic                      mret_req;
    logic                      misaligned_inst_req;
    logic                      misaligned_mem_req;
    logic [`RV_XLEN-1:0]       id_pc;
    logic [`RV_XLEN-1:0]       ex_pc;
    logic [`RV_XLEN-1:0]       mem_pc;
    logic                      csr_sw_we;
    logic [`RV_CSR_ADDR_W-1:0] csr_sw_addr;
    logic [`RV_XLEN-1:0]       csr_sw_wdata;
    logic [`RV_XLEN-1:0]       csr_sw_rdata;
    logic                      pc_stall;
    logic                      redirect_valid;
    logic [`RV_XLEN-1:0]       redirect_pc;
    logic                      ic_flush;
    logic                      debug_mode;

    // expectations handed to the checker
    logic                      exp_go;
    logic [2:0]                exp_len;
    logic                      exp_redirect;
    logic [`RV_XLEN-1:0]       exp_redirect_pc;
    logic                      exp_flush;
    logic                      exp_debug_set;
    logic                      exp_debug_clr;
    logic                      rd_check;
    logic [`RV_XLEN-1:0]       rd_expect;
    logic                      report;
    integer                    errors;
    integer                    timeouts;

    integer                    seed = 32'h1ce8;
    integer                    i;
    logic [5:0]                mask;
    logic [5:0]                stray;
    logic [`RV_XLEN-1:0]       m_mtvec;     // register model
    logic [`RV_XLEN-1:0]       m_mepc;
    logic [`RV_XLEN-1:0]       m_mcause;

    assign {misaligned_mem_req, misaligned_inst_req, mret_req,
            fencei_req, ebreak_req, ecall_req} = req_bits;

    trap_unit_top uut (
        .clk                 (clk),
        .reset               (reset),
        .ecall_req           (ecall_req),
        .ebreak_req          (ebreak_req),
        .fencei_req          (fencei_req),
        .mret_req            (mret_req),
        .misaligned_inst_req (misaligned_inst_req),
        .misaligned_mem_req  (misaligned_mem_req),
        .id_pc               (id_pc),
        .ex_pc               (ex_pc),
        .mem_pc              (mem_pc),
        .csr_sw_we           (csr_sw_we),
        .csr_sw_addr         (csr_sw_addr),
        .csr_sw_wdata        (csr_sw_wdata),
        .csr_sw_rdata        (csr_sw_rdata),
        .pc_stall            (pc_stall),
        .redirect_valid      (redirect_valid),
        .redirect_pc         (redirect_pc),
        .ic_flush            (ic_flush),
        .debug_mode          (debug_mode)
    );

    trap_unit_checker checker_inst (
        .clk             (clk),
        .reset           (reset),
        .pc_stall        (pc_stall),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .ic_flush        (ic_flush),
        .debug_mode      (debug_mode),
        .csr_sw_addr     (csr_sw_addr),
        .csr_sw_rdata    (csr_sw_rdata),
        .exp_go          (exp_go),
        .exp_len         (exp_len),
        .exp_redirect    (exp_redirect),
        .exp_redirect_pc (exp_redirect_pc),
        .exp_flush       (exp_flush),
        .exp_debug_set   (exp_debug_set),
        .exp_debug_clr   (exp_debug_clr),
        .rd_check        (rd_check),
        .rd_expect       (rd_expect),
        .timeouts        (timeouts),
        .report          (report),
        .errors          (errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory faults first, fence.i last
    function automatic trap_pkg::trap_kind_t highest_request(input logic [5:0] bits);
        trap_pkg::trap_kind_t k;
        k = trap_pkg::TRAP_NONE;
        if (bits[5]) k = trap_pkg::TRAP_MISALIGNED_MEM;
        else if (bits[4]) k = trap_pkg::TRAP_MISALIGNED_INST;
        else if (bits[0]) k = trap_pkg::TRAP_ECALL;
        else if (bits[1]) k = trap_pkg::TRAP_EBREAK;
        else if (bits[3]) k = trap_pkg::TRAP_MRET;
        else if (bits[2]) k = trap_pkg::TRAP_FENCEI;
        return k;
    endfunction

    function automatic outcome_t expected_outcome(input trap_pkg::trap_kind_t kind,
            input logic [`RV_XLEN-1:0] ipc, input logic [`RV_XLEN-1:0] xpc,
            input logic [`RV_XLEN-1:0] mpc, input logic [`RV_XLEN-1:0] mtvec,
            input logic [`RV_XLEN-1:0] mepc);
        outcome_t o;
        o = '0;
        // handler entry writes mepc and mcause then jumps to mtvec
        o.stall_len   = 3'd4;
        o.redirect    = 1'b1;
        o.redirect_pc = mtvec;
        o.writes      = 1'b1;
        case (kind)
            trap_pkg::TRAP_ECALL: begin
                o.mepc   = ipc;
                o.mcause = csr_pkg::CAUSE_ECALL_M;
            end
            trap_pkg::TRAP_MISALIGNED_INST: begin
                o.mepc   = xpc;
                o.mcause = csr_pkg::CAUSE_INST_MISALIGNED;
            end
            trap_pkg::TRAP_MISALIGNED_MEM: begin
                o.mepc   = mpc;
                o.mcause = csr_pkg::CAUSE_LOAD_MISALIGNED;
            end
            trap_pkg::TRAP_EBREAK: begin
                o.stall_len   = 3'd3;
                o.redirect    = 1'b0;
                o.redirect_pc = '0;
                o.mepc        = xpc;
                o.mcause      = csr_pkg::CAUSE_BREAKPOINT;
                o.debug_set   = 1'b1;
            end
            trap_pkg::TRAP_MRET: begin
                o             = '0;
                o.stall_len   = 3'd1;
                o.redirect    = 1'b1;
                o.redirect_pc = (mepc & ~`RV_XLEN'(3)) + `RV_XLEN'(4);
                o.debug_clr   = 1'b1;
            end
            trap_pkg::TRAP_FENCEI: begin
                o           = '0;
                o.stall_len = 3'd1;
                o.flush     = 1'b1;
            end
            default: o = '0;
        endcase
        return o;
    endfunction

    task automatic write_mtvec(input logic [`RV_XLEN-1:0] val);
        csr_sw_we    = 1'b1;
        csr_sw_addr  = csr_pkg::CSR_MTVEC;
        csr_sw_wdata = val;
        @(posedge clk);
        #2;
        csr_sw_we = 1'b0;
        m_mtvec   = val;
    endtask

    task automatic read_csr(input logic [`RV_CSR_ADDR_W-1:0] addr,
            input logic [`RV_XLEN-1:0] want);
        csr_sw_addr = addr;
        rd_expect   = want;
        rd_check    = 1'b1;
        @(posedge clk);
        #2;
        rd_check = 1'b0;
    endtask

    // pulse mask in cycle 0, stray pulses while stalled, then wait for release
    task automatic run_trap(input logic [5:0] bits, input logic [5:0] late_bits);
        outcome_t exp;
        integer   n;
        id_pc  = $random(seed);
        ex_pc  = $random(seed);
        mem_pc = $random(seed);
        exp = expected_outcome(highest_request(bits), id_pc, ex_pc, mem_pc, m_mtvec, m_mepc);
        req_bits        = bits;
        exp_go          = 1'b1;
        exp_len         = exp.stall_len;
        exp_redirect    = exp.redirect;
        exp_redirect_pc = exp.redirect_pc;
        exp_flush       = exp.flush;
        exp_debug_set   = exp.debug_set;
        exp_debug_clr   = exp.debug_clr;
        @(posedge clk);
        #2;
        exp_go   = 1'b0;
        req_bits = late_bits;
        @(posedge clk);
        #2;
        req_bits = 6'b0;
        n = 0;
        while (pc_stall && n < 10) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (pc_stall) begin
            $display("timeout: pc_stall still high %0d cycles after the trap", n);
            timeouts++;
        end
        if (exp.writes) begin
            m_mepc   = exp.mepc;
            m_mcause = exp.mcause;
        end
        read_csr(csr_pkg::CSR_MEPC, m_mepc);
        read_csr(csr_pkg::CSR_MCAUSE, m_mcause);
        read_csr(csr_pkg::CSR_MTVEC, m_mtvec);
    endtask

    initial begin
        reset           = 1'b1;
        req_bits        = 6'b0;
        id_pc           = '0;
        ex_pc           = '0;
        mem_pc          = '0;
        csr_sw_we       = 1'b0;
        csr_sw_addr     = '0;
        csr_sw_wdata    = '0;
        exp_go          = 1'b0;
        exp_len         = 3'd0;
        exp_redirect    = 1'b0;
        exp_redirect_pc = '0;
        exp_flush       = 1'b0;
        exp_debug_set   = 1'b0;
        exp_debug_clr   = 1'b0;
        rd_check        = 1'b0;
        rd_expect       = '0;
        report          = 1'b0;
        timeouts        = 0;
        m_mtvec         = '0;
        m_mepc          = '0;
        m_mcause        = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        write_mtvec($random(seed) & ~32'h3);
        run_trap(6'b000001, 6'b0);          // ecall
        run_trap(6'b010000, 6'b0);          // misaligned fetch
        run_trap(6'b100000, 6'b0);          // misaligned load/store
        run_trap(6'b000010, 6'b0);          // ebreak into debug
        run_trap(6'b001000, 6'b0);          // mret back out
        run_trap(6'b000100, 6'b0);          // fence.i
        run_trap(6'b001101, 6'b100010);     // ecall wins and the late pulses are dropped
        run_trap(6'b111111, 6'b111111);

        for (i = 0; i < 200; i++) begin
            if (($random(seed) & 7) == 0) begin
                write_mtvec($random(seed) & ~32'h3);
            end
            mask = 6'($random(seed));
            if (mask == 6'b0) begin
                mask = 6'b000100;
            end
            stray = (($random(seed) & 1) != 0) ? 6'($random(seed)) : 6'b0;
            run_trap(mask, stray);
        end

        report = 1'b1;
        #1;
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+src
src/trap_pkg.sv
src/csr_pkg.sv
src/trap_detector.sv
src/trap_controller.sv
src/machine_csr_file.sv
src/trap_unit_top.sv
verif/trap_unit_checker.sv
verif/trap_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := trap_unit_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) src/rv_defines.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
